// ==== dv/tb_orange_tracker.sv ====
// ======================================================================
// Orange tracker testbench
// Random and directed frames, remote commands and a UART decoder,
// checked against a model of the colour, zone and drive rules
// ======================================================================
`timescale 1ns/1ps

module tb_orange_tracker;
  import tracker_pkg::*;

  localparam int LW         = 12;
  localparam int MIN_CNT    = 4;
  localparam int CPB        = 8;
  // Four lines per frame
  localparam int NPIX       = LW * 4;
  localparam int WAIT_LIMIT = 400;
  localparam rgb444_t ORANGE_PIX = 12'hE70;
  localparam rgb444_t BACK_PIX   = 12'h2A3;

  logic                clk;
  logic                rst;
  logic                pix_in_valid;
  logic                pix_in_ready;
  rgb444_t             pix_in_data;
  logic                pix_in_eol;
  logic                pix_in_eof;
  logic                pix_out_valid;
  logic                pix_out_ready;
  rgb888_t             pix_out_data;
  logic                pix_out_target;
  logic                pix_out_eol;
  logic                pix_out_eof;
  logic                cmd_valid;
  logic [7:0]          cmd_code;
  logic                orange_detected;
  dir_t                direction;
  logic [COUNT_W-1:0]  orange_count;
  drive_t              drive_state;
  logic                uart_txd;

  rgb444_t     frame_pix [0:NPIX-1];
  logic [7:0]  rx_q [$];
  logic        rx_busy;
  logic [31:0] lfsr;
  // Reference drive model
  logic        model_armed;
  drive_t      model_state;
  int          test_errs;
  int          total_errs;
  int          tests_run;
  int          tests_failed;

  orange_tracker_top #(.LINE_WIDTH(LW), .ORANGE_MIN(MIN_CNT), .CLKS_PER_BIT(CPB)) uut (.*);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // Hard limit on simulated time
  initial begin
    #500_000;
    $display("simulation time limit reached before the tests finished");
    $display("TEST FAIL");
    $finish;
  end

  // Galois LFSR, right shifting
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    if (s[0])
      return (s >> 1) ^ 32'h8020_0003;
    return s >> 1;
  endfunction

  // One LFSR step per bit taken
  task automatic take_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      v    = {v[30:0], lfsr[0]};
      lfsr = lfsr_next(lfsr);
    end
  endtask

  function automatic bit is_orange(input rgb444_t p);
    return (p[11:8] >= R_MIN) && (p[7:4] >= G_MIN) && (p[7:4] <= G_MAX) &&
           (p[3:0] <= B_MAX);
  endfunction

  function automatic rgb888_t expected_rgb(input rgb444_t p);
    if (is_orange(p))
      return MARKER_RGB;
    return {p[11:8], p[11:8], p[7:4], p[7:4], p[3:0], p[3:0]};
  endfunction

  task automatic check_hex(input string name, input logic [31:0] got,
                           input logic [31:0] exp);
    assert (got === exp) else begin
      $display("ERROR %s got %h expected %h", name, got, exp);
      test_errs++;
    end
  endtask

  task automatic report_timeout(input string what);
    $display("timeout, %s", what);
    test_errs++;
  endtask

  task automatic fill_background();
    for (int i = 0; i < NPIX; i++)
      frame_pix[i] = BACK_PIX;
  endtask

  task automatic put_targets(input int line, input int col, input int n);
    for (int i = 0; i < n; i++)
      frame_pix[line * LW + col + i] = ORANGE_PIX;
  endtask

  task automatic fill_random();
    logic [31:0] sel;
    logic [31:0] v;
    for (int i = 0; i < NPIX; i++) begin
      take_bits(1, sel);
      if (sel[0]) begin
        // Red high and blue low, so many land inside the window
        take_bits(9, v);
        frame_pix[i] = {2'b11, v[8:7], v[6:3], 1'b0, v[2:0]};
      end else begin
        take_bits(12, v);
        frame_pix[i] = v[11:0];
      end
    end
  endtask

  // Streams frame_pix in and checks every output beat in order
  task automatic run_frame(input bit stall);
    int          sent;
    int          got;
    int          cyc;
    logic [31:0] r;
    sent = 0;
    got  = 0;
    cyc  = 0;
    while ((got < NPIX) && (cyc < WAIT_LIMIT)) begin
      @(negedge clk);
      cyc++;
      take_bits(2, r);
      pix_out_ready = stall ? (r[1:0] != 2'b00) : 1'b1;
      pix_in_valid  = (sent < NPIX);
      pix_in_data   = (sent < NPIX) ? frame_pix[sent] : '0;
      pix_in_eol    = (sent < NPIX) && ((sent % LW) == LW - 1);
      pix_in_eof    = (sent == NPIX - 1);
      #1;
      // Transfers happen on the coming rising edge
      if (pix_out_valid && pix_out_ready) begin
        check_hex("pix_out_data", pix_out_data, expected_rgb(frame_pix[got]));
        check_hex("pix_out_target", pix_out_target, is_orange(frame_pix[got]));
        check_hex("pix_out_eol", pix_out_eol, (got % LW) == LW - 1);
        check_hex("pix_out_eof", pix_out_eof, got == NPIX - 1);
        got++;
      end
      if (pix_in_valid && pix_in_ready)
        sent++;
    end
    if (got < NPIX)
      report_timeout("pixel stream did not drain");
  endtask

  // Zone and drive model, compared once the report has settled
  task automatic check_report();
    int   l;
    int   c;
    int   r;
    dir_t d;
    logic det;
    l = 0;
    c = 0;
    r = 0;
    // Report one cycle after eof, drive state one cycle later
    repeat (2) @(negedge clk);
    for (int i = 0; i < NPIX; i++) begin
      if (is_orange(frame_pix[i])) begin
        if ((i % LW) < LW / 3)
          l++;
        else if ((i % LW) >= (2 * LW) / 3)
          r++;
        else
          c++;
      end
    end
    det = (l + c + r) >= MIN_CNT;
    if (!det)
      d = DIR_NONE;
    else if ((c >= l) && (c >= r))
      d = DIR_CENTRE;
    else if (l >= r)
      d = DIR_LEFT;
    else
      d = DIR_RIGHT;
    if (model_armed) begin
      if (!det)
        model_state = SEARCH;
      else if (d == DIR_LEFT)
        model_state = TURN_LEFT;
      else if (d == DIR_RIGHT)
        model_state = TURN_RIGHT;
      else
        model_state = FORWARD;
    end
    check_hex("orange_detected", orange_detected, det);
    check_hex("direction", direction, d);
    check_hex("orange_count", orange_count, l + c + r);
    check_hex("drive_state", drive_state, model_state);
  endtask

  task automatic send_cmd(input logic [7:0] code);
    @(negedge clk);
    cmd_valid = 1'b1;
    cmd_code  = code;
    @(negedge clk);
    cmd_valid = 1'b0;
    if (code == CMD_ARM)
      model_armed = 1'b1;
    if (code == CMD_HALT) begin
      model_armed = 1'b0;
      model_state = STOP;
    end
    check_hex("drive_state", drive_state, model_state);
  endtask

  task automatic expect_char(input logic [7:0] exp);
    int         cyc;
    logic [7:0] ch;
    cyc = 0;
    while ((rx_q.size() == 0) && (cyc < WAIT_LIMIT)) begin
      @(negedge clk);
      cyc++;
    end
    if (rx_q.size() == 0) begin
      report_timeout("no UART character arrived");
    end else begin
      ch = rx_q.pop_front();
      check_hex("uart_char", ch, exp);
    end
  endtask

  task automatic expect_silence();
    // Longer than one whole character
    repeat (20 * CPB) @(negedge clk);
    assert ((rx_q.size() == 0) && !rx_busy) else begin
      $display("UART sent a character while none was due");
      test_errs++;
    end
  endtask

  task automatic finish_test(input string name);
    tests_run++;
    if (test_errs != 0)
      tests_failed++;
    $display("test %0d %s: %s", tests_run, name, (test_errs == 0) ? "passed" : "failed");
    total_errs += test_errs;
    test_errs = 0;
  endtask

  // Serial decoder, samples at bit centres
  initial begin : uart_decoder
    logic [7:0] b;
    rx_busy = 1'b0;
    forever begin
      @(negedge clk);
      if (!rst && (uart_txd === 1'b0)) begin
        rx_busy = 1'b1;
        repeat (CPB / 2) @(negedge clk);
        assert (uart_txd === 1'b0) else begin
          $display("UART start bit was not low at its centre");
          test_errs++;
        end
        for (int i = 0; i < 8; i++) begin
          repeat (CPB) @(negedge clk);
          b[i] = uart_txd;
        end
        repeat (CPB) @(negedge clk);
        assert (uart_txd === 1'b1) else begin
          $display("UART stop bit was not high");
          test_errs++;
        end
        rx_q.push_back(b);
        rx_busy = 1'b0;
      end
    end
  end

  initial begin
    lfsr          = 32'h03a9_ca8c;
    rst           = 1'b1;
    pix_in_valid  = 1'b0;
    pix_in_data   = '0;
    pix_in_eol    = 1'b0;
    pix_in_eof    = 1'b0;
    pix_out_ready = 1'b1;
    cmd_valid     = 1'b0;
    cmd_code      = '0;
    model_armed   = 1'b0;
    model_state   = STOP;
    test_errs     = 0;
    total_errs    = 0;
    tests_run     = 0;
    tests_failed  = 0;
    repeat (5) @(negedge clk);
    rst = 1'b0;

    fill_random();
    run_frame(1'b1);
    check_report();
    finish_test("colour rule under back-pressure");

    fill_background();
    put_targets(0, 8, 3);
    put_targets(2, 10, 2);
    run_frame(1'b0);
    check_report();
    finish_test("right zone detection");

    // Three left against three centre, then three alone
    fill_background();
    put_targets(0, 0, 3);
    put_targets(1, 4, 3);
    run_frame(1'b0);
    check_report();
    fill_background();
    put_targets(3, 4, 3);
    run_frame(1'b0);
    check_report();
    finish_test("tie-break and minimum count");

    fill_background();
    put_targets(1, 0, 4);
    put_targets(3, 3, 1);
    run_frame(1'b0);
    check_report();
    expect_silence();
    finish_test("disarmed");

    send_cmd(CMD_ARM);
    run_frame(1'b0);
    check_report();
    expect_char("L");
    fill_background();
    run_frame(1'b0);
    check_report();
    expect_char("Q");
    finish_test("armed steering");

    send_cmd(CMD_HALT);
    expect_char("S");
    put_targets(0, 8, 3);
    put_targets(2, 10, 2);
    run_frame(1'b0);
    check_report();
    expect_silence();
    finish_test("halt");

    $display("tests run %0d, tests failed %0d, checks failed %0d",
             tests_run, tests_failed, total_errs);
    if (total_errs == 0)
      $display("TEST PASS");
    else
      $display("TEST FAIL");
    $finish;
  end

endmodule

// ==== dv/tracker_assert.sv ====
// ======================================================================
// Orange tracker assertions
// Stream hold, input ready, marker colour, report and UART idle
// checks, bound to the top level
// ======================================================================
`timescale 1ns/1ps

module tracker_assert (
  input logic                 clk,
  input logic                 rst,
  input logic                 pix_in_ready,
  input logic                 pix_out_valid,
  input logic                 pix_out_ready,
  input tracker_pkg::rgb888_t pix_out_data,
  input logic                 pix_out_target,
  input logic                 pix_out_eol,
  input logic                 pix_out_eof,
  input logic                 orange_detected,
  input tracker_pkg::dir_t    direction,
  input logic                 uart_txd,
  input logic                 tx_ready
);
  import tracker_pkg::*;

  // A stalled beat keeps its payload
  stall_hold: assert property (@(posedge clk) disable iff (rst)
    pix_out_valid && !pix_out_ready |=> pix_out_valid && $stable(pix_out_data) &&
      $stable(pix_out_target) && $stable(pix_out_eol) && $stable(pix_out_eof))
    else $error("stalled output beat changed");

  // Input ready falls only with the output stage full and stalled
  in_ready_full: assert property (@(posedge clk) disable iff (rst)
    !pix_in_ready |-> pix_out_valid && !pix_out_ready)
    else $error("input ready low while the pipeline could accept");

  marker_colour: assert property (@(posedge clk) disable iff (rst)
    pix_out_valid && pix_out_target |-> pix_out_data == MARKER_RGB)
    else $error("target beat without the marker colour");

  no_direction: assert property (@(posedge clk) disable iff (rst)
    !orange_detected |-> direction == DIR_NONE)
    else $error("direction set without a detection");

  // Stream empty and line idle straight out of reset
  reset_stream: assert property (@(posedge clk) rst |=> !pix_out_valid && pix_in_ready)
    else $error("pixel stream not idle after reset");
  reset_line: assert property (@(posedge clk) rst |=> uart_txd && tx_ready)
    else $error("UART line not idle after reset");

  // Line goes low only inside a frame and so stays high until the first start bit
  txd_in_frame: assert property (@(posedge clk) disable iff (rst)
    !uart_txd |-> !tx_ready)
    else $error("UART line low outside a frame");

endmodule

bind orange_tracker_top tracker_assert u_tracker_assert (
  .clk(clk),
  .rst(rst),
  .pix_in_ready(pix_in_ready),
  .pix_out_valid(pix_out_valid),
  .pix_out_ready(pix_out_ready),
  .pix_out_data(pix_out_data),
  .pix_out_target(pix_out_target),
  .pix_out_eol(pix_out_eol),
  .pix_out_eof(pix_out_eof),
  .orange_detected(orange_detected),
  .direction(direction),
  .uart_txd(uart_txd),
  .tx_ready(tx_ready)
);

// ==== project.f ====
verilog/tracker_pkg.sv
verilog/pixel_stream_if.sv
verilog/target_finder.sv
verilog/column_classifier.sv
verilog/drive_fsm.sv
verilog/uart_tx.sv
verilog/orange_tracker_top.sv
dv/tracker_assert.sv
dv/tb_orange_tracker.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Compile and run the orange tracker testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  -f project.f --top-module tb_orange_tracker -o tb_orange_tracker

sim_out=$(./obj_dir/tb_orange_tracker)
echo "$sim_out"

if echo "$sim_out" | grep -qx "TEST PASS"; then
  exit 0
fi
exit 1

// ==== verilog/column_classifier.sv ====
// ======================================================================
// Column classifier
// Counts orange pixels in left, centre and right zones of each frame
// and publishes a direction report on the end-of-frame transfer
// ======================================================================
`timescale 1ns/1ps

module column_classifier #(
  parameter int LINE_WIDTH = 12,
  parameter int ORANGE_MIN = 4
) (
  input  logic                             clk,
  input  logic                             rst,
  pixel_stream_if.monitor                  mon,
  output logic                             report_valid,
  output tracker_pkg::dir_t                direction,
  output logic                             detected,
  output logic [tracker_pkg::COUNT_W-1:0]  orange_count
);
  import tracker_pkg::*;

  localparam int COL_W = (LINE_WIDTH > 1) ? $clog2(LINE_WIDTH) : 1;
  // Zone boundaries in columns
  localparam int LEFT_END    = LINE_WIDTH / 3;
  localparam int RIGHT_START = (2 * LINE_WIDTH) / 3;

  logic [COL_W-1:0]   col;
  logic [COUNT_W-1:0] left_cnt;
  logic [COUNT_W-1:0] centre_cnt;
  logic [COUNT_W-1:0] right_cnt;
  logic [COUNT_W-1:0] left_nxt;
  logic [COUNT_W-1:0] centre_nxt;
  logic [COUNT_W-1:0] right_nxt;
  logic [COUNT_W+1:0] sum_wide;
  logic [COUNT_W-1:0] total;
  logic               xfer;
  logic               hit;
  logic               in_left;
  logic               in_right;
  logic               found;
  dir_t               dir_nxt;

  // Add one unless the counter is already full
  function automatic logic [COUNT_W-1:0] sat_inc(input logic [COUNT_W-1:0] a,
                                                  input logic inc);
    if (inc && (a != '1))
      return a + 1'b1;
    return a;
  endfunction

  assign xfer     = mon.valid && mon.ready;
  assign hit      = xfer && mon.target;
  assign in_left  = (col < COL_W'(LEFT_END));
  assign in_right = (col >= COL_W'(RIGHT_START));

  // Counts including the current beat, so the eof pixel is counted
  assign left_nxt   = sat_inc(left_cnt, hit && in_left);
  assign right_nxt  = sat_inc(right_cnt, hit && in_right);
  assign centre_nxt = sat_inc(centre_cnt, hit && !in_left && !in_right);

  // Frame total saturates at the counter maximum
  assign sum_wide = {2'b00, left_nxt} + {2'b00, centre_nxt} + {2'b00, right_nxt};
  assign total    = (|sum_wide[COUNT_W+1:COUNT_W]) ? '1 : sum_wide[COUNT_W-1:0];
  assign found    = (total >= COUNT_W'(ORANGE_MIN));

  // Largest zone wins, centre before left before right on ties
  always_comb begin
    if (!found)
      dir_nxt = DIR_NONE;
    else if ((centre_nxt >= left_nxt) && (centre_nxt >= right_nxt))
      dir_nxt = DIR_CENTRE;
    else if (left_nxt >= right_nxt)
      dir_nxt = DIR_LEFT;
    else
      dir_nxt = DIR_RIGHT;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      col          <= '0;
      left_cnt     <= '0;
      centre_cnt   <= '0;
      right_cnt    <= '0;
      report_valid <= 1'b0;
      direction    <= DIR_NONE;
      detected     <= 1'b0;
      orange_count <= '0;
    end else begin
      report_valid <= 1'b0;
      if (xfer) begin
        // Column restarts at each line end
        if (mon.eol || mon.eof)
          col <= '0;
        else
          col <= col + 1'b1;
        if (mon.eof) begin
          report_valid <= 1'b1;
          direction    <= dir_nxt;
          detected     <= found;
          orange_count <= total;
          left_cnt     <= '0;
          centre_cnt   <= '0;
          right_cnt    <= '0;
        end else begin
          left_cnt   <= left_nxt;
          centre_cnt <= centre_nxt;
          right_cnt  <= right_nxt;
        end
      end
    end
  end

endmodule

// ==== verilog/drive_fsm.sv ====
// ======================================================================
// Drive state machine
// Arm and halt commands, steering from direction reports, and one
// pending UART character for each change of drive state
// ======================================================================
`timescale 1ns/1ps

module drive_fsm (
  input  logic                clk,
  input  logic                rst,
  input  logic                cmd_valid,
  input  logic [7:0]          cmd_code,
  input  logic                report_valid,
  input  tracker_pkg::dir_t   direction,
  input  logic                detected,
  output tracker_pkg::drive_t drive_state,
  output logic                tx_valid,
  input  logic                tx_ready,
  output logic [7:0]          tx_byte
);
  import tracker_pkg::*;

  logic   armed;
  logic   armed_nxt;
  logic   cmd_arm;
  logic   cmd_halt;
  drive_t state_nxt;

  assign cmd_arm  = cmd_valid && (cmd_code == CMD_ARM);
  assign cmd_halt = cmd_valid && (cmd_code == CMD_HALT);

  // Commands take priority over a report in the same cycle
  always_comb begin
    armed_nxt = armed;
    state_nxt = drive_state;
    if (cmd_arm) begin
      armed_nxt = 1'b1;
    end else if (cmd_halt) begin
      armed_nxt = 1'b0;
      state_nxt = STOP;
    end else if (report_valid && armed) begin
      if (!detected)
        state_nxt = SEARCH;
      else
        case (direction)
          DIR_LEFT:   state_nxt = TURN_LEFT;
          DIR_RIGHT:  state_nxt = TURN_RIGHT;
          DIR_CENTRE: state_nxt = FORWARD;
          default:    state_nxt = SEARCH;
        endcase
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      armed       <= 1'b0;
      drive_state <= STOP;
      tx_valid    <= 1'b0;
    end else begin
      armed       <= armed_nxt;
      drive_state <= state_nxt;
      // New character overwrites one still waiting
      if (state_nxt != drive_state)
        tx_valid <= 1'b1;
      else if (tx_ready)
        tx_valid <= 1'b0;
    end
  end

  // Character slot payload
  always_ff @(posedge clk) begin
    if (state_nxt != drive_state)
      tx_byte <= state_char(state_nxt);
  end

endmodule

// ==== verilog/orange_tracker_top.sv ====
// ======================================================================
// Orange tracker top level
// Colour target finder, zone classifier, drive FSM and UART reporter
// ======================================================================
`timescale 1ns/1ps

module orange_tracker_top #(
  parameter int LINE_WIDTH   = 12,
  parameter int ORANGE_MIN   = 4,
  parameter int CLKS_PER_BIT = 8
) (
  input  logic                            clk,
  input  logic                            rst,
  // Frame buffer pixel stream
  input  logic                            pix_in_valid,
  output logic                            pix_in_ready,
  input  tracker_pkg::rgb444_t            pix_in_data,
  input  logic                            pix_in_eol,
  input  logic                            pix_in_eof,
  // Display pixel stream
  output logic                            pix_out_valid,
  input  logic                            pix_out_ready,
  output tracker_pkg::rgb888_t            pix_out_data,
  output logic                            pix_out_target,
  output logic                            pix_out_eol,
  output logic                            pix_out_eof,
  // Remote command byte
  input  logic                            cmd_valid,
  input  logic [7:0]                      cmd_code,
  // Status
  output logic                            orange_detected,
  output tracker_pkg::dir_t               direction,
  output logic [tracker_pkg::COUNT_W-1:0] orange_count,
  output tracker_pkg::drive_t             drive_state,
  output logic                            uart_txd
);

  logic       report_valid;
  logic       tx_valid;
  logic       tx_ready;
  logic [7:0] tx_byte;

  pixel_stream_if pix_if ();

  // Display side of the stream
  assign pix_out_valid  = pix_if.valid;
  assign pix_out_data   = pix_if.data;
  assign pix_out_target = pix_if.target;
  assign pix_out_eol    = pix_if.eol;
  assign pix_out_eof    = pix_if.eof;
  assign pix_if.ready   = pix_out_ready;

  target_finder u_target_finder (
    .clk(clk), .rst(rst),
    .in_valid(pix_in_valid), .in_ready(pix_in_ready), .in_data(pix_in_data),
    .in_eol(pix_in_eol), .in_eof(pix_in_eof),
    .out(pix_if.source));

  column_classifier #(.LINE_WIDTH(LINE_WIDTH), .ORANGE_MIN(ORANGE_MIN)) u_classifier (
    .clk(clk), .rst(rst), .mon(pix_if.monitor),
    .report_valid(report_valid), .direction(direction),
    .detected(orange_detected), .orange_count(orange_count));

  drive_fsm u_drive_fsm (
    .clk(clk), .rst(rst), .cmd_valid(cmd_valid), .cmd_code(cmd_code),
    .report_valid(report_valid), .direction(direction), .detected(orange_detected),
    .drive_state(drive_state),
    .tx_valid(tx_valid), .tx_ready(tx_ready), .tx_byte(tx_byte));

  uart_tx #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_uart_tx (
    .clk(clk), .rst(rst), .tx_valid(tx_valid), .tx_ready(tx_ready),
    .tx_byte(tx_byte), .txd(uart_txd));

endmodule

// ==== verilog/pixel_stream_if.sv ====
// ======================================================================
// Pixel stream interface
// Valid/ready RGB888 stream with target, end-of-line and end-of-frame
// ======================================================================
`timescale 1ns/1ps

interface pixel_stream_if;
  import tracker_pkg::*;

  // Handshake
  logic    valid;
  logic    ready;
  // Payload, held while valid and not ready
  rgb888_t data;
  logic    target;
  logic    eol;
  logic    eof;

  // Producer side
  modport source (output valid, output data, output target, output eol,
                  output eof, input ready);

  // Consumer side
  modport sink (input valid, input data, input target, input eol,
                input eof, output ready);

  // Passive observer of transfers
  modport monitor (input valid, input ready, input data, input target,
                   input eol, input eof);

endinterface

// ==== verilog/target_finder.sv ====
// ======================================================================
// Target finder
// Two-stage pipeline that tests each RGB444 pixel against the orange
// window and emits either the marker colour or the expanded RGB888
// ======================================================================
`timescale 1ns/1ps

module target_finder (
  input  logic                clk,
  input  logic                rst,
  input  logic                in_valid,
  output logic                in_ready,
  input  tracker_pkg::rgb444_t in_data,
  input  logic                in_eol,
  input  logic                in_eof,
  pixel_stream_if.source      out
);
  import tracker_pkg::*;

  // Stage one holds the raw pixel and its window compares
  logic    s1_valid;
  rgb444_t s1_pix;
  logic    s1_eol;
  logic    s1_eof;
  logic    s1_r_ok;
  logic    s1_g_ok;
  logic    s1_b_ok;

  // Stage two holds the finished output beat
  logic    s2_valid;
  rgb888_t s2_data;
  logic    s2_target;
  logic    s2_eol;
  logic    s2_eof;

  logic    s1_adv;
  logic    s2_adv;
  logic    s1_hit;

  // A stage moves when empty or when the next one moves
  assign s2_adv = !s2_valid || out.ready;
  assign s1_adv = !s1_valid || s2_adv;
  // Ready drops only with both stages full and the sink stalled
  assign in_ready = s1_adv;

  assign s1_hit = s1_r_ok && s1_g_ok && s1_b_ok;

  // Valid flags
  always_ff @(posedge clk) begin
    if (rst) begin
      s1_valid <= 1'b0;
      s2_valid <= 1'b0;
    end else begin
      if (s1_adv)
        s1_valid <= in_valid;
      if (s2_adv)
        s2_valid <= s1_valid;
    end
  end

  // Stage one payload and colour window compares
  always_ff @(posedge clk) begin
    if (s1_adv) begin
      s1_pix  <= in_data;
      s1_eol  <= in_eol;
      s1_eof  <= in_eof;
      s1_r_ok <= (in_data[11:8] >= R_MIN);
      s1_g_ok <= (in_data[7:4] >= G_MIN) && (in_data[7:4] <= G_MAX);
      s1_b_ok <= (in_data[3:0] <= B_MAX);
    end
  end

  // Stage two, marker or nibble-duplicated colour
  always_ff @(posedge clk) begin
    if (s2_adv) begin
      s2_target <= s1_hit;
      s2_eol    <= s1_eol;
      s2_eof    <= s1_eof;
      if (s1_hit)
        s2_data <= MARKER_RGB;
      else
        s2_data <= {s1_pix[11:8], s1_pix[11:8], s1_pix[7:4], s1_pix[7:4],
                    s1_pix[3:0], s1_pix[3:0]};
    end
  end

  // Drive the outgoing stream
  assign out.valid  = s2_valid;
  assign out.data   = s2_data;
  assign out.target = s2_target;
  assign out.eol    = s2_eol;
  assign out.eof    = s2_eof;

endmodule

// ==== verilog/tracker_pkg.sv ====
// ======================================================================
// Orange tracker shared definitions
// Pixel formats, direction and drive state encodings, colour window
// limits, command codes and the UART character for each drive state
// ======================================================================
package tracker_pkg;

  // Frame buffer pixel, R in [11:8], G in [7:4], B in [3:0]
  typedef logic [11:0] rgb444_t;
  // Display pixel, R in the top byte
  typedef logic [23:0] rgb888_t;

  // One-hot steering direction
  typedef enum logic [2:0] {
    DIR_NONE   = 3'b000,
    DIR_RIGHT  = 3'b001,
    DIR_CENTRE = 3'b010,
    DIR_LEFT   = 3'b100
  } dir_t;

  typedef enum logic [2:0] {
    STOP       = 3'd0,
    FORWARD    = 3'd1,
    TURN_LEFT  = 3'd2,
    TURN_RIGHT = 3'd3,
    SEARCH     = 3'd4
  } drive_t;

  // Frame orange count width
  localparam int COUNT_W = 18;

  // Orange window, in 4-bit channel units
  localparam logic [3:0] R_MIN = 4'hC;
  localparam logic [3:0] G_MIN = 4'h4;
  localparam logic [3:0] G_MAX = 4'hA;
  localparam logic [3:0] B_MAX = 4'h5;

  // Pure green replaces every orange pixel
  localparam rgb888_t MARKER_RGB = 24'h00FF00;

  localparam logic [7:0] CMD_ARM  = 8'h01;
  localparam logic [7:0] CMD_HALT = 8'h02;

  // ASCII report character of a drive state
  function automatic logic [7:0] state_char(input drive_t s);
    case (s)
      STOP:       return "S";
      FORWARD:    return "F";
      TURN_LEFT:  return "L";
      TURN_RIGHT: return "R";
      default:    return "Q";
    endcase
  endfunction

endpackage

// ==== verilog/uart_tx.sv ====
// ======================================================================
// UART transmitter
// 8N1 serial output, LSB first, fed by a valid/ready byte port
// ======================================================================
`timescale 1ns/1ps

module uart_tx #(
  parameter int CLKS_PER_BIT = 8
) (
  input  logic       clk,
  input  logic       rst,
  input  logic       tx_valid,
  output logic       tx_ready,
  input  logic [7:0] tx_byte,
  output logic       txd
);

  localparam int CNT_W = $clog2(CLKS_PER_BIT + 1);

  logic             busy;
  logic [CNT_W-1:0] clk_cnt;
  // 0 is the start bit, 1..8 data, 9 the stop bit
  logic [3:0]       bit_idx;
  // Remaining data bits with the stop bit on top
  logic [8:0]       shift;
  logic             bit_end;

  assign tx_ready = !busy;
  assign bit_end  = (clk_cnt == CNT_W'(CLKS_PER_BIT - 1));

  always_ff @(posedge clk) begin
    if (rst) begin
      busy    <= 1'b0;
      clk_cnt <= '0;
      bit_idx <= '0;
      txd     <= 1'b1;
    end else if (!busy) begin
      if (tx_valid) begin
        // Start bit goes out from the next cycle
        busy    <= 1'b1;
        clk_cnt <= '0;
        bit_idx <= '0;
        txd     <= 1'b0;
      end
    end else if (bit_end) begin
      clk_cnt <= '0;
      if (bit_idx == 4'd9) begin
        // Stop bit done, line stays idle high
        busy <= 1'b0;
      end else begin
        bit_idx <= bit_idx + 1'b1;
        txd     <= shift[0];
      end
    end else begin
      clk_cnt <= clk_cnt + 1'b1;
    end
  end

  // Shift register payload
  always_ff @(posedge clk) begin
    if (!busy && tx_valid)
      shift <= {1'b1, tx_byte};
    else if (busy && bit_end)
      shift <= {1'b1, shift[8:1]};
  end

endmodule
